//--- design/hart_pkg.sv
package hart_pkg;

  // data and address width of the hart
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;   // register value, pc or instruction word
  typedef logic [4:0]      reg_addr_t;  // index into x0..x31

  // major opcodes this hart decodes, anything else traps
  typedef enum logic [6:0] {
    OP     = 7'b0110011,  // register-register alu ops
    OP_IMM = 7'b0010011,  // register-immediate alu ops
    LUI    = 7'b0110111,  // load upper immediate
    SYSTEM = 7'b1110011   // only ebreak is accepted here
  } opcode_t;

  // alu operations selected in decode and carried to execute
  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,     // signed compare, result is 0 or 1
    SLL,     // shift amount is operand b[4:0]
    SRL,
    PASS_B   // lui just forwards the u-type immediate
  } alu_op_e;

  // ebreak has no operands so the whole word is fixed
  localparam word_t EBREAK_WORD = 32'h0010_0073;

  // addi x0, x0, 0 fills the pipeline registers until real words arrive
  localparam word_t NOP_WORD = 32'h0000_0013;

  // no branches or jumps, so the pc always moves by one word
  localparam word_t PC_STEP = 32'd4;

endpackage

//--- design/id_ex_if.sv
`timescale 1ns/1ps

// one decoded instruction on its way from decode to execute
interface id_ex_if;
  import hart_pkg::*;

  logic      valid;      // low while post-reset fill words move through
  word_t     inst;       // raw word, carried for the retire port
  word_t     pc;
  alu_op_e   alu_op;
  reg_addr_t rs1_addr;   // zero when the instruction does not read rs1
  reg_addr_t rs2_addr;   // zero when the instruction does not read rs2
  word_t     rs1_data;   // register file data read in decode
  word_t     rs2_data;
  word_t     imm;
  logic      use_imm;    // operand b is imm instead of rs2
  reg_addr_t rd_addr;
  logic      writes_rd;  // already cleared for traps, halt and x0
  logic      trap;
  logic      halt;

  modport producer (output valid, inst, pc, alu_op, rs1_addr, rs2_addr, rs1_data, rs2_data,
                    imm, use_imm, rd_addr, writes_rd, trap, halt);
  modport consumer (input valid, inst, pc, alu_op, rs1_addr, rs2_addr, rs1_data, rs2_data,
                    imm, use_imm, rd_addr, writes_rd, trap, halt);

endinterface

//--- design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
  parameter hart_pkg::word_t RESET_ADDR = 32'h0000_0000
) (
  input  logic            i_clk,
  input  logic            i_rst,
  input  hart_pkg::word_t i_imem_rdata,  // word for the address sent last cycle
  output hart_pkg::word_t o_imem_raddr,
  output hart_pkg::word_t o_if_inst,
  output hart_pkg::word_t o_if_pc,
  output logic            o_if_valid
);
  import hart_pkg::*;

  word_t pc;         // address presented to imem this cycle
  word_t req_pc;     // address of the read whose word is on i_imem_rdata now
  logic  req_valid;  // low in the first cycle after reset, nothing has returned yet

  assign o_imem_raddr = pc;  // the pc register drives the imem port directly

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc         <= RESET_ADDR;
      req_valid  <= 1'b0;
      o_if_valid <= 1'b0;
    end else begin
      pc         <= pc + PC_STEP;  // never stalls, so always step
      req_valid  <= 1'b1;
      o_if_valid <= req_valid;     // first real word lands one cycle later
    end
  end

  // if/id payload pairs the returning word with the pc it was fetched from
  always_ff @(posedge i_clk) begin
    req_pc    <= pc;
    o_if_pc   <= req_pc;
    o_if_inst <= req_valid ? i_imem_rdata : NOP_WORD;  // fill with nop until words return
  end

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic               i_clk,
  input  logic               i_rst,
  input  hart_pkg::reg_addr_t i_rs1_addr,
  input  hart_pkg::reg_addr_t i_rs2_addr,
  output hart_pkg::word_t    o_rs1_data,
  output hart_pkg::word_t    o_rs2_data,
  input  logic               i_wb_en,
  input  hart_pkg::reg_addr_t i_wb_addr,
  input  hart_pkg::word_t    i_wb_data
);
  import hart_pkg::*;

  word_t regs [1:31];  // x0 has no storage

  // one read port, x0 is hardwired zero and a same-cycle write is passed through
  function automatic word_t read_port(input reg_addr_t addr);
    if (addr == '0) return '0;
    if (i_wb_en && (i_wb_addr == addr)) return i_wb_data;  // covers the distance-two case
    return regs[addr];
  endfunction

  // both read ports follow the write port and the storage as well as the address
  always_comb begin
    o_rs1_data = read_port(i_rs1_addr);
    o_rs2_data = read_port(i_rs2_addr);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;  // programs start from a known all-zero state
      end
    end else if (i_wb_en && (i_wb_addr != '0)) begin
      regs[i_wb_addr] <= i_wb_data;
    end
  end

endmodule

//--- design/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
  input  logic                i_clk,
  input  logic                i_rst,
  input  hart_pkg::word_t     i_if_inst,
  input  hart_pkg::word_t     i_if_pc,
  input  logic                i_if_valid,
  output hart_pkg::reg_addr_t o_rs1_addr,  // to the register file read ports
  output hart_pkg::reg_addr_t o_rs2_addr,
  input  hart_pkg::word_t     i_rs1_data,
  input  hart_pkg::word_t     i_rs2_data,
  id_ex_if.producer           id_ex
);
  import hart_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd;
  alu_op_e    alu_op;
  word_t      imm;
  logic       use_imm;
  logic       reads_rs1;
  logic       reads_rs2;
  logic       writes;
  logic       trap;
  logic       halt;

  assign opcode = opcode_t'(i_if_inst[6:0]);  // values outside the enum fall to default
  assign funct3 = i_if_inst[14:12];
  assign funct7 = i_if_inst[31:25];
  assign rd     = i_if_inst[11:7];

  always_comb begin
    alu_op    = ADD;
    use_imm   = 1'b0;
    reads_rs1 = 1'b0;
    reads_rs2 = 1'b0;
    writes    = 1'b0;
    trap      = 1'b0;
    halt      = 1'b0;
    imm       = {{20{i_if_inst[31]}}, i_if_inst[31:20]};  // i-type, sign extended
    case (opcode)
      OP: begin
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
        writes    = 1'b1;
        case ({funct7, funct3})  // funct7 must be zero except for sub
          {7'h00, 3'b000}: alu_op = ADD;
          {7'h20, 3'b000}: alu_op = SUB;
          {7'h00, 3'b111}: alu_op = AND;
          {7'h00, 3'b110}: alu_op = OR;
          {7'h00, 3'b100}: alu_op = XOR;
          {7'h00, 3'b010}: alu_op = SLT;
          {7'h00, 3'b001}: alu_op = SLL;
          {7'h00, 3'b101}: alu_op = SRL;
          default:         trap   = 1'b1;  // sltu, sra and friends are not kept
        endcase
      end
      OP_IMM: begin
        reads_rs1 = 1'b1;
        use_imm   = 1'b1;
        writes    = 1'b1;
        case (funct3)
          3'b000:  alu_op = ADD;
          3'b111:  alu_op = AND;
          3'b110:  alu_op = OR;
          3'b100:  alu_op = XOR;
          3'b010:  alu_op = SLT;
          3'b001: begin
            alu_op = SLL;
            trap   = (funct7 != 7'h00);  // upper bits of a shift imm must be zero
          end
          3'b101: begin
            alu_op = SRL;
            trap   = (funct7 != 7'h00);  // srai would land here, not supported
          end
          default: trap = 1'b1;  // sltiu
        endcase
      end
      LUI: begin
        alu_op  = PASS_B;
        use_imm = 1'b1;
        writes  = 1'b1;
        imm     = {i_if_inst[31:12], 12'h000};  // u-type immediate
      end
      SYSTEM: begin
        halt = (i_if_inst == EBREAK_WORD);
        trap = (i_if_inst != EBREAK_WORD);  // ecall, csr ops are not kept
      end
      default: trap = 1'b1;
    endcase
    if (trap) begin
      // a trapping word reads and writes nothing
      reads_rs1 = 1'b0;
      reads_rs2 = 1'b0;
      writes    = 1'b0;
    end
    if (halt || (rd == '0)) writes = 1'b0;  // writes to x0 are dropped here once
  end

  assign o_rs1_addr = reads_rs1 ? i_if_inst[19:15] : '0;
  assign o_rs2_addr = reads_rs2 ? i_if_inst[24:20] : '0;

  // control half of id/ex, fill words never raise a flag
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      id_ex.valid     <= 1'b0;
      id_ex.writes_rd <= 1'b0;
      id_ex.trap      <= 1'b0;
      id_ex.halt      <= 1'b0;
    end else begin
      id_ex.valid     <= i_if_valid;
      id_ex.writes_rd <= i_if_valid & writes;
      id_ex.trap      <= i_if_valid & trap;
      id_ex.halt      <= i_if_valid & halt;
    end
  end

  always_ff @(posedge i_clk) begin
    id_ex.inst     <= i_if_inst;
    id_ex.pc       <= i_if_pc;
    id_ex.alu_op   <= alu_op;
    id_ex.rs1_addr <= o_rs1_addr;
    id_ex.rs2_addr <= o_rs2_addr;
    id_ex.rs1_data <= i_rs1_data;  // already includes the write-through value
    id_ex.rs2_data <= i_rs2_data;
    id_ex.imm      <= imm;
    id_ex.use_imm  <= use_imm;
    id_ex.rd_addr  <= rd;
  end

endmodule

//--- design/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
  input  logic                i_clk,
  input  logic                i_rst,
  id_ex_if.consumer           id_ex,
  output logic                o_wb_en,
  output hart_pkg::reg_addr_t o_wb_addr,
  output hart_pkg::word_t     o_wb_data,
  output logic                o_retire_valid,
  output logic                o_retire_trap,
  output logic                o_retire_halt,
  output hart_pkg::word_t     o_retire_inst,
  output hart_pkg::reg_addr_t o_retire_rs1_raddr,
  output hart_pkg::reg_addr_t o_retire_rs2_raddr,
  output hart_pkg::word_t     o_retire_rs1_rdata,
  output hart_pkg::word_t     o_retire_rs2_rdata,
  output hart_pkg::reg_addr_t o_retire_rd_waddr,
  output hart_pkg::word_t     o_retire_rd_wdata,
  output hart_pkg::word_t     o_retire_pc,
  output hart_pkg::word_t     o_retire_next_pc
);
  import hart_pkg::*;

  word_t rs1_val;     // rs1 after forwarding
  word_t rs2_val;
  word_t op_b;
  word_t alu_result;

  // ex/wb register
  logic      wb_valid;
  logic      wb_writes;
  logic      wb_trap;
  logic      wb_halt;
  word_t     wb_inst;
  word_t     wb_pc;
  reg_addr_t wb_rs1_addr;
  reg_addr_t wb_rs2_addr;
  word_t     wb_rs1_data;
  word_t     wb_rs2_data;
  reg_addr_t wb_rd;
  word_t     wb_result;

  // rs addresses are zero when unused and o_wb_en never fires for x0,
  // so a plain match means the previous instruction produced this operand
  assign rs1_val = (o_wb_en && (wb_rd == id_ex.rs1_addr)) ? wb_result : id_ex.rs1_data;
  assign rs2_val = (o_wb_en && (wb_rd == id_ex.rs2_addr)) ? wb_result : id_ex.rs2_data;
  assign op_b    = id_ex.use_imm ? id_ex.imm : rs2_val;

  always_comb begin
    case (id_ex.alu_op)
      ADD:     alu_result = rs1_val + op_b;
      SUB:     alu_result = rs1_val - op_b;
      AND:     alu_result = rs1_val & op_b;
      OR:      alu_result = rs1_val | op_b;
      XOR:     alu_result = rs1_val ^ op_b;
      SLT:     alu_result = {31'd0, $signed(rs1_val) < $signed(op_b)};
      SLL:     alu_result = rs1_val << op_b[4:0];
      SRL:     alu_result = rs1_val >> op_b[4:0];
      PASS_B:  alu_result = op_b;
      default: alu_result = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wb_valid  <= 1'b0;
      wb_writes <= 1'b0;
      wb_trap   <= 1'b0;
      wb_halt   <= 1'b0;
    end else begin
      wb_valid  <= id_ex.valid;
      wb_writes <= id_ex.writes_rd;
      wb_trap   <= id_ex.trap;
      wb_halt   <= id_ex.halt;
    end
  end

  always_ff @(posedge i_clk) begin
    wb_inst     <= id_ex.inst;
    wb_pc       <= id_ex.pc;
    wb_rs1_addr <= id_ex.rs1_addr;
    wb_rs2_addr <= id_ex.rs2_addr;
    wb_rs1_data <= rs1_val;  // retire reports the operands actually used
    wb_rs2_data <= rs2_val;
    wb_rd       <= id_ex.rd_addr;
    wb_result   <= alu_result;
  end

  assign o_wb_en   = wb_valid & wb_writes;
  assign o_wb_addr = wb_rd;
  assign o_wb_data = wb_result;

  assign o_retire_valid     = wb_valid;
  assign o_retire_trap      = wb_valid & wb_trap;
  assign o_retire_halt      = wb_valid & wb_halt;
  assign o_retire_inst      = wb_inst;
  assign o_retire_rs1_raddr = wb_rs1_addr;
  assign o_retire_rs2_raddr = wb_rs2_addr;
  assign o_retire_rs1_rdata = wb_rs1_data;
  assign o_retire_rs2_rdata = wb_rs2_data;
  assign o_retire_rd_waddr  = o_wb_en ? wb_rd : '0;  // zero for traps, halt and x0
  assign o_retire_rd_wdata  = wb_result;
  assign o_retire_pc        = wb_pc;
  assign o_retire_next_pc   = wb_pc + PC_STEP;  // no control flow, always sequential

endmodule

//--- design/hart.sv
`timescale 1ns/1ps

module hart #(
  parameter hart_pkg::word_t RESET_ADDR = 32'h0000_0000
) (
  input  logic                i_clk,
  input  logic                i_rst,
  output hart_pkg::word_t     o_imem_raddr,
  input  hart_pkg::word_t     i_imem_rdata,  // arrives one cycle after its address
  output logic                o_retire_valid,
  output logic                o_retire_trap,
  output logic                o_retire_halt,
  output hart_pkg::word_t     o_retire_inst,
  output hart_pkg::reg_addr_t o_retire_rs1_raddr,
  output hart_pkg::reg_addr_t o_retire_rs2_raddr,
  output hart_pkg::word_t     o_retire_rs1_rdata,
  output hart_pkg::word_t     o_retire_rs2_rdata,
  output hart_pkg::reg_addr_t o_retire_rd_waddr,
  output hart_pkg::word_t     o_retire_rd_wdata,
  output hart_pkg::word_t     o_retire_pc,
  output hart_pkg::word_t     o_retire_next_pc
);
  import hart_pkg::*;

  // if/id outputs of fetch
  word_t     if_inst;
  word_t     if_pc;
  logic      if_valid;

  // decode read ports into the register file
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;

  // writeback port from execute
  logic      wb_en;
  reg_addr_t wb_addr;
  word_t     wb_data;

  id_ex_if id_ex ();  // id/ex pipeline register contents

  fetch_unit #(
    .RESET_ADDR (RESET_ADDR)
  ) i_fetch (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_imem_rdata (i_imem_rdata),
    .o_imem_raddr (o_imem_raddr),
    .o_if_inst    (if_inst),
    .o_if_pc      (if_pc),
    .o_if_valid   (if_valid)
  );

  reg_file i_reg_file (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rs1_addr (rs1_addr),
    .i_rs2_addr (rs2_addr),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_wb_en    (wb_en),
    .i_wb_addr  (wb_addr),
    .i_wb_data  (wb_data)
  );

  decode_unit i_decode (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_if_inst  (if_inst),
    .i_if_pc    (if_pc),
    .i_if_valid (if_valid),
    .o_rs1_addr (rs1_addr),
    .o_rs2_addr (rs2_addr),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .id_ex      (id_ex)
  );

  execute_unit i_execute (
    .i_clk              (i_clk),
    .i_rst              (i_rst),
    .id_ex              (id_ex),
    .o_wb_en            (wb_en),
    .o_wb_addr          (wb_addr),
    .o_wb_data          (wb_data),
    .o_retire_valid     (o_retire_valid),
    .o_retire_trap      (o_retire_trap),
    .o_retire_halt      (o_retire_halt),
    .o_retire_inst      (o_retire_inst),
    .o_retire_rs1_raddr (o_retire_rs1_raddr),
    .o_retire_rs2_raddr (o_retire_rs2_raddr),
    .o_retire_rs1_rdata (o_retire_rs1_rdata),
    .o_retire_rs2_rdata (o_retire_rs2_rdata),
    .o_retire_rd_waddr  (o_retire_rd_waddr),
    .o_retire_rd_wdata  (o_retire_rd_wdata),
    .o_retire_pc        (o_retire_pc),
    .o_retire_next_pc   (o_retire_next_pc)
  );

endmodule

//--- tests/hart_properties.sv
`timescale 1ns/1ps

// checks on the retire port and the fetch address, bound into hart
module hart_properties (
  input logic                i_clk,
  input logic                i_rst,
  input hart_pkg::word_t     i_imem_raddr,
  input logic                i_retire_valid,
  input logic                i_retire_trap,
  input logic                i_retire_halt,
  input hart_pkg::reg_addr_t i_retire_rd_waddr
);

  // a reset edge leaves every retire flag inactive
  property p_retire_idle_in_reset;
    @(posedge i_clk) $past(i_rst) |-> !i_retire_valid && !i_retire_trap && !i_retire_halt;
  endproperty

  // nothing stalls or jumps, so fetch is a plain stepping counter
  property p_fetch_steps;
    @(posedge i_clk) disable iff (i_rst)
      !$past(i_rst) |-> i_imem_raddr == $past(i_imem_raddr) + 32'd4;
  endproperty

  property p_no_rd_on_trap_or_halt;
    @(posedge i_clk) disable iff (i_rst)
      i_retire_valid && (i_retire_trap || i_retire_halt) |-> i_retire_rd_waddr == '0;
  endproperty

  a_retire_idle_in_reset: assert property (p_retire_idle_in_reset)
    else $error("retire outputs active right after a reset edge");
  a_fetch_steps: assert property (p_fetch_steps)
    else $error("imem address did not step by 4");
  a_no_rd_on_trap_or_halt: assert property (p_no_rd_on_trap_or_halt)
    else $error("trap or halt retired with a destination register");

endmodule

//--- tests/tb_hart.sv
`timescale 1ns/1ps

module tb_hart;
  import hart_pkg::*;

  localparam word_t RESET_ADDR = 32'h0000_0100;
  localparam int    CLK_PERIOD = 100;
  localparam int    MAX_LINES  = 64;
  localparam int    FIELDS     = 5;              // inst, rd, rd data, trap, halt on every line
  localparam word_t FILL_WORD  = 32'h0000_0013;  // addi x0, x0, 0 outside the program

  logic      i_clk;
  logic      i_rst;
  word_t     o_imem_raddr;
  word_t     i_imem_rdata;
  logic      o_retire_valid;
  logic      o_retire_trap;
  logic      o_retire_halt;
  word_t     o_retire_inst;
  reg_addr_t o_retire_rs1_raddr;
  reg_addr_t o_retire_rs2_raddr;
  word_t     o_retire_rs1_rdata;
  word_t     o_retire_rs2_rdata;
  reg_addr_t o_retire_rd_waddr;
  word_t     o_retire_rd_wdata;
  word_t     o_retire_pc;
  word_t     o_retire_next_pc;

  word_t testdata [0:MAX_LINES*FIELDS-1];  // flat copy of the file, FIELDS words per line
  word_t reg_model [0:31];  // register values the file says the program has written so far
  int    num_lines;     // lines up to and including the ebreak line
  int    retired;       // retires seen so far
  int    errors;
  int    test_errors;   // mismatches in the retire being checked
  word_t last_raddr;    // address the DUT presented in the previous cycle
  logic  halted;

  hart #(.RESET_ADDR(RESET_ADDR)) i_dut (.*);

  bind hart hart_properties i_props (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_imem_raddr      (o_imem_raddr),
    .i_retire_valid    (o_retire_valid),
    .i_retire_trap     (o_retire_trap),
    .i_retire_halt     (o_retire_halt),
    .i_retire_rd_waddr (o_retire_rd_waddr)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // program word at an address, the program starts at RESET_ADDR
  function automatic word_t imem_word(input word_t addr);
    int idx;
    if (addr < RESET_ADDR) return FILL_WORD;
    idx = int'((addr - RESET_ADDR) >> 2);
    if (idx >= num_lines) return FILL_WORD;  // fetch runs on past the ebreak
    return testdata[idx * FIELDS];
  endfunction

  // synchronous memory, the word for last cycle's address shows up this cycle
  initial begin
    i_imem_rdata = FILL_WORD;
    last_raddr   = RESET_ADDR;
    forever begin
      @(negedge i_clk);
      i_imem_rdata = imem_word(last_raddr);
      last_raddr   = o_imem_raddr;
    end
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_reg_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      test_errors++;
    end
  endtask

  // compares one retire with line idx of the file and with the register model
  task automatic check_retire(input int idx);
    int        base;
    word_t     inst;
    logic      exp_trap;
    reg_addr_t rs1_exp;
    reg_addr_t rs2_exp;
    base        = idx * FIELDS;
    inst        = testdata[base];
    exp_trap    = testdata[base + 3][0];
    test_errors = 0;
    // op reads rs1 and rs2, op-imm only rs1, lui, ebreak and traps read nothing
    rs1_exp = (!exp_trap && (inst[6:0] inside {7'h33, 7'h13})) ? inst[19:15] : '0;
    rs2_exp = (!exp_trap && (inst[6:0] == 7'h33)) ? inst[24:20] : '0;
    check_word("o_retire_pc", o_retire_pc, RESET_ADDR + word_t'(idx * 4));  // sequential pc
    check_word("o_retire_next_pc", o_retire_next_pc, RESET_ADDR + word_t'((idx + 1) * 4));
    check_word("o_retire_inst", o_retire_inst, inst);
    check_reg_addr("o_retire_rs1_raddr", o_retire_rs1_raddr, rs1_exp);
    check_reg_addr("o_retire_rs2_raddr", o_retire_rs2_raddr, rs2_exp);
    check_word("o_retire_rs1_rdata", o_retire_rs1_rdata, reg_model[rs1_exp]);
    check_word("o_retire_rs2_rdata", o_retire_rs2_rdata, reg_model[rs2_exp]);
    check_reg_addr("o_retire_rd_waddr", o_retire_rd_waddr, reg_addr_t'(testdata[base + 1]));
    // the data lane carries nothing meaningful when no register is written
    if (testdata[base + 1] != '0) begin
      check_word("o_retire_rd_wdata", o_retire_rd_wdata, testdata[base + 2]);
      reg_model[testdata[base + 1][4:0]] = testdata[base + 2];  // later readers see this value
    end
    check_bit("o_retire_trap", o_retire_trap, exp_trap);
    check_bit("o_retire_halt", o_retire_halt, testdata[base + 4][0]);
    errors += test_errors;
    if (test_errors == 0) begin
      $display("test %0d: pc 0x%h inst 0x%h ok", idx, o_retire_pc, o_retire_inst);
    end else begin
      $display("test %0d: pc 0x%h inst 0x%h had %0d mismatches", idx, o_retire_pc,
               o_retire_inst, test_errors);
    end
  endtask

  initial begin
    i_rst     = 1'b1;
    retired   = 0;
    errors    = 0;
    halted    = 1'b0;
    num_lines = 0;
    for (int i = 0; i < 32; i++) begin
      reg_model[i] = '0;  // the register file comes out of reset all zero
    end
    for (int i = 0; i < MAX_LINES * FIELDS; i++) begin
      testdata[i] = '0;  // lines past the end never look like a halt
    end
    $readmemh("tests/hart_testdata.txt", testdata);
    for (int i = 0; i < MAX_LINES; i++) begin
      if ((num_lines == 0) && testdata[i * FIELDS + 4][0]) num_lines = i + 1;  // ebreak ends it
    end
    if (num_lines == 0) begin
      $display("the testdata file holds no line with the halt bit set");
      errors++;
    end else begin
      repeat (2) @(negedge i_clk);
      i_rst = 1'b0;
      while (!halted) begin
        @(negedge i_clk);  // retire outputs are registered and settled here
        if (o_retire_valid) begin
          if (retired < num_lines) begin
            check_retire(retired);
          end else begin
            $display("more instructions retired than the testdata file holds");
            errors++;
            halted = 1'b1;
          end
          retired++;
          if (o_retire_halt) halted = 1'b1;
        end
      end
      if (retired != num_lines) begin
        $display("%0d instructions retired up to the halt, the file has %0d lines",
                 retired, num_lines);
        errors++;
      end
    end
    $display("summary: %0d retired, %0d lines, %0d errors", retired, num_lines, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // the whole program plus pipeline fill fits easily in lines + 10 cycles
  initial begin
    @(negedge i_clk);  // file is loaded by now
    #((num_lines + 10) * CLK_PERIOD);
    $display("watchdog expired, no halt retired within %0d cycles", num_lines + 10);
    $display("TB FAILED");
    $finish;
  end

endmodule

//--- tests/hart_testdata.txt
// columns: instruction word, expected rd address, expected rd data, expected trap, expected halt
// one line per instruction in fetch order from RESET_ADDR, the last line is ebreak
00500093 01 00000005 0 0
00708113 02 0000000c 0 0
002081b3 03 00000011 0 0
12345237 04 12345000 0 0
67826293 05 12345678 0 0
fff2c313 06 edcba987 0 0
0ff37393 07 00000087 0 0
00439413 08 00000870 0 0
00835493 09 00edcba9 0 0
00032513 0a 00000001 0 0
402085b3 0b fffffff9 0 0
00002083 00 00000000 1 0
00008633 0c 00000005 0 0
0015a6b3 0d 00000001 0 0
00a09733 0e 0000000a 0 0
00a757b3 0f 00000005 0 0
0084e833 10 00edcbf9 0 0
007878b3 11 00000081 0 0
0018c933 12 00000084 0 0
00100073 00 00000000 0 1

//--- project.f
design/hart_pkg.sv
design/id_ex_if.sv
design/fetch_unit.sv
design/reg_file.sv
design/decode_unit.sv
design/execute_unit.sv
design/hart.sv
tests/hart_properties.sv
tests/tb_hart.sv

//--- run.sh
#!/usr/bin/env bash
# builds the hart testbench with verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_hart -f project.f -o tb_hart
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_hart)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
